//--- Bender.yml
package:
  name: branch_predictor

sources:
  # Shared package
  - common/bp_pkg.sv
  # BTB blocks
  - btb/btb_index_gen.sv
  - btb/btb_way.sv
  - btb/btb_hit_select.sv
  # Direction predictor and top level
  - src/predictor_unit.sv
  - src/branch_predictor.sv
  # Testbench
  - target: test
    files:
      - tb/branch_predictor_props.sv
      - tb/branch_predictor_tb.sv

//--- all.f
common/bp_pkg.sv
btb/btb_index_gen.sv
btb/btb_way.sv
btb/btb_hit_select.sv
src/predictor_unit.sv
src/branch_predictor.sv
tb/branch_predictor_props.sv
tb/branch_predictor_tb.sv

//--- btb/btb_hit_select.sv
`timescale 1ns/1ps

module btb_hit_select #(
    parameter int NUM_WAYS = 2
) (
    // Per way fetch lookup
    input  logic [NUM_WAYS - 1:0] fetch_hit_i,
    input  bp_pkg::data_word_t    fetch_target_i [NUM_WAYS],
    input  logic [NUM_WAYS - 1:0] fetch_jump_i,
    // Per way execute lookup
    input  logic [NUM_WAYS - 1:0] exec_hit_i,
    input  bp_pkg::data_word_t    exec_target_i [NUM_WAYS],
    input  logic [NUM_WAYS - 1:0] exec_jump_i,
    // Selected entries
    output logic                  fetch_hit_o,
    output bp_pkg::data_word_t    fetch_target_o,
    output logic                  fetch_jump_o,
    output logic                  exec_hit_o,
    output bp_pkg::data_word_t    exec_target_o,
    output logic                  exec_jump_o
);

    // A hit in any way is a hit of the whole BTB
    assign fetch_hit_o = |fetch_hit_i;
    assign exec_hit_o  = |exec_hit_i;

    // Allocation keeps at most one way hitting, so the hit vector is one hot.
    // Scanning downwards lets the lowest way win should that ever break
    always_comb begin
        fetch_target_o = '0;
        fetch_jump_o   = 1'b0;
        exec_target_o  = '0;
        exec_jump_o    = 1'b0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (fetch_hit_i[w]) begin
                fetch_target_o = fetch_target_i[w];
                fetch_jump_o   = fetch_jump_i[w];
            end
            if (exec_hit_i[w]) begin
                exec_target_o = exec_target_i[w];
                exec_jump_o   = exec_jump_i[w];
            end
        end
    end

endmodule : btb_hit_select

//--- btb/btb_index_gen.sv
`timescale 1ns/1ps

module btb_index_gen #(
    parameter int NUM_WAYS = 2,
    parameter int BTB_SETS = 8
) (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  bp_pkg::data_word_t                        program_counter_i,
    input  bp_pkg::data_word_t                        instr_address_i,
    input  bp_pkg::data_word_t                        branch_target_addr_i,
    input  logic                                      executed_i,
    input  logic                                      taken_i,
    input  logic                                      branch_i,
    input  logic                                      jump_i,
    input  logic [NUM_WAYS - 1:0]                     exec_hit_i,
    output logic [$clog2(BTB_SETS) - 1:0]             fetch_index_o,
    output logic [bp_pkg::tag_width(BTB_SETS) - 1:0]  fetch_tag_o,
    output logic [$clog2(BTB_SETS) - 1:0]             exec_index_o,
    output logic [bp_pkg::tag_width(BTB_SETS) - 1:0]  exec_tag_o,
    output bp_pkg::data_word_t                        write_target_o,
    output logic                                      write_jump_o,
    output logic [NUM_WAYS - 1:0]                     write_en_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(BTB_SETS);
    localparam int TAG_W = tag_width(BTB_SETS);
    // A single way still needs a one bit pointer to keep the vector legal
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Round robin victim pointer, one per set
    logic [WAY_W - 1:0] rr_ptr_q [BTB_SETS];
    logic               allocate, exec_any_hit;

    // Index sits right above the alignment bits, the tag takes everything above it
    assign fetch_index_o = program_counter_i[INSTR_ALIGN +: IDX_W];
    assign fetch_tag_o   = program_counter_i[INSTR_ALIGN + IDX_W +: TAG_W];
    assign exec_index_o  = instr_address_i[INSTR_ALIGN +: IDX_W];
    assign exec_tag_o    = instr_address_i[INSTR_ALIGN + IDX_W +: TAG_W];

    assign write_target_o = branch_target_addr_i;
    assign write_jump_o   = jump_i;

    // Only taken control transfers are worth a BTB entry
    assign allocate     = executed_i & taken_i & (branch_i | jump_i);
    assign exec_any_hit = |exec_hit_i;

    // A hitting way is rewritten in place, otherwise the set victim is replaced
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (exec_any_hit) begin
                write_en_o[w] = allocate & exec_hit_i[w];
            end else begin
                write_en_o[w] = allocate & (rr_ptr_q[exec_index_o] == WAY_W'(w));
            end
        end
    end

    // The pointer only advances when a new entry actually displaces the victim
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                rr_ptr_q[s] <= '0;
            end
        end else if (allocate && !exec_any_hit) begin
            if (rr_ptr_q[exec_index_o] == WAY_W'(NUM_WAYS - 1)) begin
                rr_ptr_q[exec_index_o] <= '0;
            end else begin
                rr_ptr_q[exec_index_o] <= rr_ptr_q[exec_index_o] + 1'b1;
            end
        end
    end

endmodule : btb_index_gen

//--- btb/btb_way.sv
`timescale 1ns/1ps

module btb_way #(
    parameter int BTB_SETS = 8
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    // Fetch read port
    input  logic [$clog2(BTB_SETS) - 1:0]            fetch_index_i,
    input  logic [bp_pkg::tag_width(BTB_SETS) - 1:0] fetch_tag_i,
    // Execute read port, its index also addresses the write
    input  logic [$clog2(BTB_SETS) - 1:0]            exec_index_i,
    input  logic [bp_pkg::tag_width(BTB_SETS) - 1:0] exec_tag_i,
    // Write port
    input  logic                                     write_en_i,
    input  bp_pkg::data_word_t                       write_target_i,
    input  logic                                     write_jump_i,
    output logic                                     fetch_hit_o,
    output bp_pkg::data_word_t                       fetch_target_o,
    output logic                                     fetch_jump_o,
    output logic                                     exec_hit_o,
    output bp_pkg::data_word_t                       exec_target_o,
    output logic                                     exec_jump_o
);

    import bp_pkg::*;

    localparam int TAG_W = tag_width(BTB_SETS);

    // --------------------
    // Storage
    // --------------------

    logic               valid_q  [BTB_SETS];
    logic [TAG_W - 1:0] tag_q    [BTB_SETS];
    data_word_t         target_q [BTB_SETS];
    logic               jump_q   [BTB_SETS];

    // Valid bits decide whether an entry exists at all
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else if (write_en_i) begin
            valid_q[exec_index_i] <= 1'b1;
        end
    end

    // Entry payload, meaningless until the valid bit is set
    always_ff @(posedge clk_i) begin
        if (write_en_i) begin
            tag_q[exec_index_i]    <= exec_tag_i;
            target_q[exec_index_i] <= write_target_i;
            jump_q[exec_index_i]   <= write_jump_i;
        end
    end

    // --------------------
    // Read ports
    // --------------------

    // Both ports compare against the stored tag without any register stage
    assign fetch_hit_o    = valid_q[fetch_index_i] && (tag_q[fetch_index_i] == fetch_tag_i);
    assign fetch_target_o = target_q[fetch_index_i];
    assign fetch_jump_o   = jump_q[fetch_index_i];

    // The execute port sees the entry before this cycle's write takes effect
    assign exec_hit_o    = valid_q[exec_index_i] && (tag_q[exec_index_i] == exec_tag_i);
    assign exec_target_o = target_q[exec_index_i];
    assign exec_jump_o   = jump_q[exec_index_i];

endmodule : btb_way

//--- common/bp_pkg.sv
package bp_pkg;

    // --------------------
    // Address layout
    // --------------------

    // Width of every instruction and target address in the core
    localparam int ADDR_W = 32;

    // Instructions are word aligned, so the two lowest address bits never carry information
    localparam int INSTR_ALIGN = 2;

    typedef logic [ADDR_W - 1:0] data_word_t;

    // Number of tag bits left above the set index for a BTB with the given set count
    function automatic int tag_width(input int sets);
        return ADDR_W - INSTR_ALIGN - $clog2(sets);
    endfunction

    // --------------------
    // Direction counters
    // --------------------

    // Two bit saturating counter, the upper half of the range predicts taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

endpackage : bp_pkg

//--- src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int NUM_WAYS       = 2,
    parameter int BTB_SETS       = 8,
    parameter int PREDICTOR_SIZE = 32
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               stall_i,
    // Fetch side lookup
    input  logic               valid_i,
    input  bp_pkg::data_word_t program_counter_i,
    // Resolved branch or jump from the execute unit
    input  bp_pkg::data_word_t instr_address_i,
    input  bp_pkg::data_word_t branch_target_addr_i,
    input  logic               executed_i,
    input  logic               taken_i,
    input  logic               branch_i,
    input  logic               jump_i,
    // Registered prediction towards fetch
    output bp_pkg::data_word_t branch_target_addr_o,
    output logic               prediction_o,
    output logic               mispredicted_o,
    output logic               hit_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(BTB_SETS);
    localparam int TAG_W = tag_width(BTB_SETS);

    // Address fields and write controls shared by all ways
    logic [IDX_W - 1:0]    fetch_index, exec_index;
    logic [TAG_W - 1:0]    fetch_tag, exec_tag;
    data_word_t            write_target;
    logic                  write_jump;
    logic [NUM_WAYS - 1:0] write_en;

    // Raw per way lookup results
    logic [NUM_WAYS - 1:0] way_fetch_hit, way_fetch_jump;
    logic [NUM_WAYS - 1:0] way_exec_hit, way_exec_jump;
    data_word_t            way_fetch_target [NUM_WAYS];
    data_word_t            way_exec_target [NUM_WAYS];

    // Lookup results after way selection
    logic       fetch_hit, fetch_jump, exec_hit, exec_jump;
    data_word_t fetch_target, exec_target;

    // --------------------
    // BTB
    // --------------------

    btb_index_gen #(
        .NUM_WAYS ( NUM_WAYS ),
        .BTB_SETS ( BTB_SETS )
    ) u_btb_index_gen (
        .clk_i                ( clk_i                ),
        .rst_i                ( rst_i                ),
        .program_counter_i    ( program_counter_i    ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .executed_i           ( executed_i           ),
        .taken_i              ( taken_i              ),
        .branch_i             ( branch_i             ),
        .jump_i               ( jump_i               ),
        .exec_hit_i           ( way_exec_hit         ),
        .fetch_index_o        ( fetch_index          ),
        .fetch_tag_o          ( fetch_tag            ),
        .exec_index_o         ( exec_index           ),
        .exec_tag_o           ( exec_tag             ),
        .write_target_o       ( write_target         ),
        .write_jump_o         ( write_jump           ),
        .write_en_o           ( write_en             )
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        btb_way #(
            .BTB_SETS ( BTB_SETS )
        ) u_btb_way (
            .clk_i          ( clk_i               ),
            .rst_i          ( rst_i               ),
            .fetch_index_i  ( fetch_index         ),
            .fetch_tag_i    ( fetch_tag           ),
            .exec_index_i   ( exec_index          ),
            .exec_tag_i     ( exec_tag            ),
            .write_en_i     ( write_en[w]         ),
            .write_target_i ( write_target        ),
            .write_jump_i   ( write_jump          ),
            .fetch_hit_o    ( way_fetch_hit[w]    ),
            .fetch_target_o ( way_fetch_target[w] ),
            .fetch_jump_o   ( way_fetch_jump[w]   ),
            .exec_hit_o     ( way_exec_hit[w]     ),
            .exec_target_o  ( way_exec_target[w]  ),
            .exec_jump_o    ( way_exec_jump[w]    )
        );
    end

    btb_hit_select #(
        .NUM_WAYS ( NUM_WAYS )
    ) u_btb_hit_select (
        .fetch_hit_i    ( way_fetch_hit    ),
        .fetch_target_i ( way_fetch_target ),
        .fetch_jump_i   ( way_fetch_jump   ),
        .exec_hit_i     ( way_exec_hit     ),
        .exec_target_i  ( way_exec_target  ),
        .exec_jump_i    ( way_exec_jump    ),
        .fetch_hit_o    ( fetch_hit        ),
        .fetch_target_o ( fetch_target     ),
        .fetch_jump_o   ( fetch_jump       ),
        .exec_hit_o     ( exec_hit         ),
        .exec_target_o  ( exec_target      ),
        .exec_jump_o    ( exec_jump        )
    );

    // --------------------
    // Direction predictor
    // --------------------

    predictor_unit #(
        .PREDICTOR_SIZE ( PREDICTOR_SIZE )
    ) u_predictor_unit (
        .clk_i                ( clk_i                ),
        .rst_i                ( rst_i                ),
        .flush_i              ( flush_i              ),
        .stall_i              ( stall_i              ),
        .valid_i              ( valid_i              ),
        .program_counter_i    ( program_counter_i    ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .executed_i           ( executed_i           ),
        .taken_i              ( taken_i              ),
        .branch_i             ( branch_i             ),
        .jump_i               ( jump_i               ),
        .fetch_hit_i          ( fetch_hit            ),
        .fetch_target_i       ( fetch_target         ),
        .fetch_jump_i         ( fetch_jump           ),
        .exec_hit_i           ( exec_hit             ),
        .exec_target_i        ( exec_target          ),
        .exec_jump_i          ( exec_jump            ),
        .hit_o                ( hit_o                ),
        .prediction_o         ( prediction_o         ),
        .branch_target_addr_o ( branch_target_addr_o ),
        .mispredicted_o       ( mispredicted_o       )
    );

endmodule : branch_predictor

//--- src/predictor_unit.sv
`timescale 1ns/1ps

module predictor_unit #(
    parameter int PREDICTOR_SIZE = 32
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  bp_pkg::data_word_t program_counter_i,
    input  bp_pkg::data_word_t instr_address_i,
    input  bp_pkg::data_word_t branch_target_addr_i,
    input  logic               executed_i,
    input  logic               taken_i,
    input  logic               branch_i,
    input  logic               jump_i,
    // Selected BTB entries for both ports
    input  logic               fetch_hit_i,
    input  bp_pkg::data_word_t fetch_target_i,
    input  logic               fetch_jump_i,
    input  logic               exec_hit_i,
    input  bp_pkg::data_word_t exec_target_i,
    input  logic               exec_jump_i,
    output logic               hit_o,
    output logic               prediction_o,
    output bp_pkg::data_word_t branch_target_addr_o,
    output logic               mispredicted_o
);

    import bp_pkg::*;

    localparam int CNT_W = $clog2(PREDICTOR_SIZE);

    counter_t           cnt_q [PREDICTOR_SIZE];
    logic [CNT_W - 1:0] fetch_cnt_idx, exec_cnt_idx;
    logic               fetch_pred, exec_pred, resolved, mispredict;

    // Upper half of the counter range means taken
    function automatic logic cnt_taken(input counter_t c);
        return (c == WEAK_T) || (c == STRONG_T);
    endfunction

    // One step towards the outcome, saturating at both ends
    function automatic counter_t cnt_next(input counter_t c, input logic taken);
        case (c)
            STRONG_NT: return taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   return taken ? WEAK_T : STRONG_NT;
            WEAK_T:    return taken ? STRONG_T : WEAK_NT;
            default:   return taken ? STRONG_T : WEAK_T;
        endcase
    endfunction

    assign fetch_cnt_idx = program_counter_i[INSTR_ALIGN +: CNT_W];
    assign exec_cnt_idx  = instr_address_i[INSTR_ALIGN +: CNT_W];

    // Jumps always redirect, branches follow their counter
    assign fetch_pred = fetch_hit_i & (fetch_jump_i | cnt_taken(cnt_q[fetch_cnt_idx]));
    assign exec_pred  = exec_hit_i & (exec_jump_i | cnt_taken(cnt_q[exec_cnt_idx]));

    // --------------------
    // Fetch stage register
    // --------------------

    // Flush beats stall, stall freezes the previous lookup
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hit_o        <= 1'b0;
            prediction_o <= 1'b0;
        end else if (flush_i) begin
            hit_o        <= 1'b0;
            prediction_o <= 1'b0;
        end else if (!stall_i) begin
            hit_o        <= valid_i & fetch_hit_i;
            prediction_o <= valid_i & fetch_pred;
        end
    end

    // Target only matters while hit_o is high
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            branch_target_addr_o <= fetch_target_i;
        end
    end

    // --------------------
    // Update and mispredict
    // --------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < PREDICTOR_SIZE; i++) begin
                cnt_q[i] <= WEAK_NT;
            end
        end else if (executed_i && branch_i) begin
            // Jumps never train the counters
            cnt_q[exec_cnt_idx] <= cnt_next(cnt_q[exec_cnt_idx], taken_i);
        end
    end

    assign resolved = executed_i & (branch_i | jump_i);

    // Wrong direction, or right direction towards a stale target
    assign mispredict = resolved & ((exec_pred != taken_i) |
                        (exec_pred & taken_i & (exec_target_i != branch_target_addr_i)));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mispredicted_o <= 1'b0;
        end else begin
            mispredicted_o <= mispredict;
        end
    end

endmodule : predictor_unit

//--- tb/branch_predictor_props.sv
`timescale 1ns/1ps

module branch_predictor_props (
    input logic clk_i,
    input logic rst_i,
    input logic flush_i,
    input logic executed_i,
    input logic hit_o,
    input logic prediction_o,
    input logic mispredicted_o
);

    // Number of property failures seen so far
    int unsigned error_count = 0;

    // --------------------
    // Output protocol
    // --------------------

    // Every registered output leaves reset cleared
    reset_clears: assert property (@(posedge clk_i)
        rst_i |=> (!hit_o && !prediction_o && !mispredicted_o))
        else begin
            $error("outputs not cleared after reset");
            error_count++;
        end

    // A redirect without a BTB entry would have no target
    pred_needs_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        prediction_o |-> hit_o)
        else begin
            $error("prediction_o high without hit_o");
            error_count++;
        end

    // The mispredict pulse always belongs to the strobe one cycle earlier
    mis_after_exec: assert property (@(posedge clk_i) disable iff (rst_i)
        mispredicted_o |-> $past(executed_i))
        else begin
            $error("mispredicted_o without executed_i in the previous cycle");
            error_count++;
        end

    // Flush drops the lookup even while stalled
    flush_clears_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |=> !hit_o)
        else begin
            $error("hit_o still high after flush_i");
            error_count++;
        end

endmodule : branch_predictor_props

//--- tb/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb;

    import bp_pkg::*;

    localparam int NUM_ROWS = 24;

    // Addresses picked so that every behavior lives in its own BTB set
    localparam data_word_t Z     = 32'h0000_0000;
    localparam data_word_t B0    = 32'h0000_0108;
    localparam data_word_t B0_T  = 32'h0000_0180;
    localparam data_word_t B1    = 32'h0000_0104;
    localparam data_word_t B1_T  = 32'h0000_0200;
    localparam data_word_t B1_T2 = 32'h0000_0300;
    localparam data_word_t J1    = 32'h0000_010C;
    localparam data_word_t J1_T  = 32'h0000_0400;
    // Three branches in set 0 with distinct counters 0, 8 and 16
    localparam data_word_t C1    = 32'h0000_1000;
    localparam data_word_t C2    = 32'h0000_1020;
    localparam data_word_t C3    = 32'h0000_1040;
    localparam data_word_t C1_T  = 32'h0000_2000;
    localparam data_word_t C2_T  = 32'h0000_2100;
    localparam data_word_t C3_T  = 32'h0000_2200;

    logic       clk_i, rst_i, flush_i, stall_i, valid_i;
    logic       executed_i, taken_i, branch_i, jump_i;
    data_word_t program_counter_i, instr_address_i, branch_target_addr_i;
    data_word_t branch_target_addr_o;
    logic       prediction_o, mispredicted_o, hit_o;

    // Stimulus and expected values, one entry per cycle
    string      row_name [NUM_ROWS];
    logic       row_valid [NUM_ROWS], row_stall [NUM_ROWS], row_flush [NUM_ROWS];
    logic       row_exe [NUM_ROWS], row_taken [NUM_ROWS], row_br [NUM_ROWS];
    logic       row_jmp [NUM_ROWS];
    data_word_t row_pc [NUM_ROWS], row_addr [NUM_ROWS], row_tgt [NUM_ROWS];
    logic       exp_hit [NUM_ROWS], exp_pred [NUM_ROWS], exp_mis [NUM_ROWS];
    data_word_t exp_tgt [NUM_ROWS];
    int         row_cnt = 0;

    branch_predictor #(
        .NUM_WAYS       ( 2  ),
        .BTB_SETS       ( 8  ),
        .PREDICTOR_SIZE ( 32 )
    ) u_branch_predictor (
        .clk_i                ( clk_i                ),
        .rst_i                ( rst_i                ),
        .flush_i              ( flush_i              ),
        .stall_i              ( stall_i              ),
        .valid_i              ( valid_i              ),
        .program_counter_i    ( program_counter_i    ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .executed_i           ( executed_i           ),
        .taken_i              ( taken_i              ),
        .branch_i             ( branch_i             ),
        .jump_i               ( jump_i               ),
        .branch_target_addr_o ( branch_target_addr_o ),
        .prediction_o         ( prediction_o         ),
        .mispredicted_o       ( mispredicted_o       ),
        .hit_o                ( hit_o                )
    );

    bind branch_predictor branch_predictor_props u_branch_predictor_props (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .flush_i        ( flush_i        ),
        .executed_i     ( executed_i     ),
        .hit_o          ( hit_o          ),
        .prediction_o   ( prediction_o   ),
        .mispredicted_o ( mispredicted_o )
    );

    always #5 clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic add_row(input string name, input logic valid, input data_word_t pc,
                           input logic stall, input logic flush, input logic exe,
                           input data_word_t addr, input data_word_t tgt, input logic taken,
                           input logic br, input logic jmp, input logic e_hit,
                           input logic e_pred, input data_word_t e_tgt, input logic e_mis);
        row_name[row_cnt]  = name;
        row_valid[row_cnt] = valid;
        row_pc[row_cnt]    = pc;
        row_stall[row_cnt] = stall;
        row_flush[row_cnt] = flush;
        row_exe[row_cnt]   = exe;
        row_addr[row_cnt]  = addr;
        row_tgt[row_cnt]   = tgt;
        row_taken[row_cnt] = taken;
        row_br[row_cnt]    = br;
        row_jmp[row_cnt]   = jmp;
        exp_hit[row_cnt]   = e_hit;
        exp_pred[row_cnt]  = e_pred;
        exp_tgt[row_cnt]   = e_tgt;
        exp_mis[row_cnt]   = e_mis;
        row_cnt++;
    endtask

    task automatic drive_row(input int i);
        valid_i              = row_valid[i];
        program_counter_i    = row_pc[i];
        stall_i              = row_stall[i];
        flush_i              = row_flush[i];
        executed_i           = row_exe[i];
        instr_address_i      = row_addr[i];
        branch_target_addr_i = row_tgt[i];
        taken_i              = row_taken[i];
        branch_i             = row_br[i];
        jump_i               = row_jmp[i];
    endtask

    // Fetch outputs registered on the edge of row i
    task automatic check_fetch(input int i);
        assert (hit_o === exp_hit[i]) else abort_run($sformatf(
            "Error %s: hit_o expected %0b, actual %0b", row_name[i], exp_hit[i], hit_o));
        assert (prediction_o === exp_pred[i]) else abort_run($sformatf(
            "Error %s: prediction_o expected %0b, actual %0b", row_name[i], exp_pred[i],
            prediction_o));
        // The target carries no meaning without a hit
        if (exp_hit[i]) begin
            assert (branch_target_addr_o === exp_tgt[i]) else abort_run($sformatf(
                "Error %s: branch_target_addr_o expected %h, actual %h", row_name[i],
                exp_tgt[i], branch_target_addr_o));
        end
    endtask

    task automatic check_mispredict(input string name, input logic exp);
        assert (mispredicted_o === exp) else abort_run($sformatf(
            "Error %s: mispredicted_o expected %0b, actual %0b", name, exp, mispredicted_o));
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        // Columns: name, valid pc stall flush, exe addr tgt taken br jmp,
        // expected hit pred target, expected mispredict of the previous row
        add_row("cold_fetch",      1, B1, 0, 0, 0, Z,  Z,     0, 0, 0, 0, 0, Z,     0);
        add_row("cold_taken",      0, Z,  0, 0, 1, B1, B1_T,  1, 1, 0, 0, 0, Z,     0);
        add_row("one_taken_fetch", 1, B1, 0, 0, 1, B0, B0_T,  0, 1, 0, 1, 1, B1_T,  1);
        add_row("second_taken",    0, Z,  0, 0, 1, B1, B1_T,  1, 1, 0, 0, 0, Z,     0);
        add_row("strong_fetch",    1, B1, 0, 0, 1, B1, B1_T,  0, 1, 0, 1, 1, B1_T,  0);
        add_row("hyst_fetch",      1, B1, 0, 0, 1, B1, B1_T,  0, 1, 0, 1, 1, B1_T,  1);
        add_row("weak_nt_fetch",   1, B1, 0, 0, 1, J1, J1_T,  1, 0, 1, 1, 0, B1_T,  1);
        add_row("jump_fetch",      1, J1, 0, 0, 1, B1, B1_T,  1, 1, 0, 1, 1, J1_T,  1);
        add_row("retarget",        1, J1, 0, 0, 1, B1, B1_T2, 1, 1, 0, 1, 1, J1_T,  1);
        add_row("new_target",      1, B1, 0, 0, 0, Z,  Z,     0, 0, 0, 1, 1, B1_T2, 1);
        add_row("jump_again",      1, J1, 0, 0, 1, J1, J1_T,  1, 0, 1, 1, 1, J1_T,  0);
        add_row("conflict_c1",     0, Z,  0, 0, 1, C1, C1_T,  1, 1, 0, 0, 0, Z,     0);
        add_row("conflict_c2",     1, C1, 0, 0, 1, C2, C2_T,  1, 1, 0, 1, 1, C1_T,  1);
        add_row("conflict_c3",     1, C2, 0, 0, 1, C3, C3_T,  1, 1, 0, 1, 1, C2_T,  1);
        add_row("evicted_c1",      1, C1, 0, 0, 0, Z,  Z,     0, 0, 0, 0, 0, Z,     1);
        add_row("c2_still",        1, C2, 0, 0, 0, Z,  Z,     0, 0, 0, 1, 1, C2_T,  0);
        add_row("c3_hit",          1, C3, 0, 0, 0, Z,  Z,     0, 0, 0, 1, 1, C3_T,  0);
        add_row("stall_hold",      1, C1, 1, 0, 0, Z,  Z,     0, 0, 0, 1, 1, C3_T,  0);
        add_row("stall_hold2",     1, B0, 1, 0, 0, Z,  Z,     0, 0, 0, 1, 1, C3_T,  0);
        add_row("flush_stalled",   1, C2, 1, 1, 0, Z,  Z,     0, 0, 0, 0, 0, Z,     0);
        add_row("after_flush",     1, C2, 0, 0, 0, Z,  Z,     0, 0, 0, 1, 1, C2_T,  0);
        add_row("valid_low",       0, C2, 0, 0, 0, Z,  Z,     0, 0, 0, 0, 0, Z,     0);
        add_row("b1_final",        1, B1, 0, 0, 1, B0, B0_T,  0, 1, 0, 1, 1, B1_T2, 0);
        add_row("idle_end",        0, Z,  0, 0, 0, Z,  Z,     0, 0, 0, 0, 0, Z,     0);

        // The first row sits on the inputs through reset, it executes nothing
        drive_row(0);

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Each falling edge first checks the previous row, then drives the next one
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_fetch(i - 1);
            end
            check_mispredict(row_name[i], exp_mis[i]);
            drive_row(i);
        end
        @(negedge clk_i);
        check_fetch(NUM_ROWS - 1);
        check_mispredict("final", 1'b0);

        // The bound protocol checker keeps its own count of failed properties
        if (u_branch_predictor.u_branch_predictor_props.error_count != 0) begin
            abort_run("A protocol assertion on the DUT outputs failed during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Reset, all rows and some slack, doubled
    initial begin
        #((3 + NUM_ROWS + 10) * 10 * 2);
        abort_run("Timeout: the stimulus table did not finish in the expected time");
    end

endmodule : branch_predictor_tb
